//--- qu_retire.f
source/qu_pkg.sv
source/rob.sv
source/retire.sv
source/phy_rf.sv
source/busy_table.sv
source/retire_top.sv
verif/retire_tb.sv

//--- Bender.yml
package:
  name: qu_retire

sources:
  - files:
      - source/qu_pkg.sv
      - source/rob.sv
      - source/retire.sv
      - source/phy_rf.sv
      - source/busy_table.sv
      - source/retire_top.sv
  - target: test
    files:
      - verif/retire_tb.sv

//--- verif/retire_tb.sv
// Testbench with clock, reset, LFSR, data memory responder, compare tasks and directed tests
module retire_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROB_DEPTH = 16;
    localparam int PHY_REGS = 64;
    localparam int RETIRE_LIMIT = 8;
    // Reset, defaults, ALU, stores, load, branches, full flag
    localparam int TEST_CYCLES = 8 + 2 + 20 + 16 + 16 + 8 + 24;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 64;

    typedef struct packed {
        logic [3:0]  strb;
        logic [31:0] addr;
        logic [31:0] data;
    } store_rec_t;

    logic                 clk;
    logic                 rst;
    qu_pkg::phy_rf_data_t value_in;
    logic                 comp_result_in;
    qu_pkg::res_st_cell_t op_in;
    logic                 rob_incr_tail_ptr;
    qu_pkg::rob_addr_t    rob_tail_ptr;
    logic                 rob_full;
    logic                 free_reg_en;
    qu_pkg::phy_rf_addr_t free_reg_addr;
    logic                 retire_en;
    qu_pkg::rob_addr_t    retire_rob_addr;
    qu_pkg::phy_rf_data_t retire_value;
    logic                 mispredicted_branch;
    qu_pkg::pc_t          pc_to_jump;
    logic [3:0]           dmem_wr_en;
    logic                 dmem_rd_en;
    logic [31:0]          dmem_addr;
    logic [31:0]          dmem_data;
    logic                 dmem_valid_in;
    logic [31:0]          dmem_data_in;
    logic                 busy_set_en;
    qu_pkg::phy_rf_addr_t busy_set_addr;
    qu_pkg::phy_rf_addr_t rf_rd_addr;
    qu_pkg::phy_rf_data_t rf_rd_data;
    qu_pkg::phy_rf_addr_t busy_rd_addr;
    logic                 busy_rd_data;

    logic [31:0] lfsr_state = 32'h59f55b2c;
    logic [31:0] mem [16];
    store_rec_t  store_log [$];
    int          tail_model;

    retire_top #(
        .ROB_DEPTH(ROB_DEPTH),
        .PHY_REGS (PHY_REGS)
    ) DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_data(input qu_pkg::phy_rf_data_t got, input qu_pkg::phy_rf_data_t exp,
                              input string name);
        if (got !== exp)
        begin
            fail_run($sformatf("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input qu_pkg::phy_rf_addr_t got, input qu_pkg::phy_rf_addr_t exp,
                              input string name);
        if (got !== exp)
        begin
            fail_run($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_rob(input qu_pkg::rob_addr_t got, input qu_pkg::rob_addr_t exp,
                             input string name);
        if (got !== exp)
        begin
            fail_run($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_strobe(input logic [3:0] got, input logic [3:0] exp, input string name);
        if (got !== exp)
        begin
            fail_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp)
        begin
            fail_run($sformatf("Mismatch at %0d ns: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    // Falling edge with the per-cycle strobes dropped
    task automatic next_cycle();
        @(negedge clk);
        rob_incr_tail_ptr = 1'b0;
        busy_set_en = 1'b0;
        op_in = '0;
        comp_result_in = 1'b0;
    endtask

    task automatic allocate(input qu_pkg::phy_rf_addr_t dest, output qu_pkg::rob_addr_t slot);
        next_cycle();
        check_rob(rob_tail_ptr, qu_pkg::rob_addr_t'(tail_model), "rob_tail_ptr");
        slot = qu_pkg::rob_addr_t'(tail_model);
        rob_incr_tail_ptr = 1'b1;
        busy_set_en = (dest != '0);
        busy_set_addr = dest;
        tail_model = (tail_model + 1) % ROB_DEPTH;
    endtask

    task automatic complete(input qu_pkg::optype_t kind, input qu_pkg::funct3_t width,
                            input qu_pkg::rob_addr_t slot, input qu_pkg::phy_rf_addr_t dest,
                            input qu_pkg::phy_rf_addr_t old, input qu_pkg::phy_rf_data_t vk,
                            input qu_pkg::phy_rf_data_t value, input logic taken);
        next_cycle();
        op_in.op.optype = kind;
        op_in.op.funct3 = width;
        op_in.rob_addr = slot;
        op_in.dest = dest;
        op_in.phyreg_old = old;
        op_in.vk = vk;
        value_in = value;
        comp_result_in = taken;
    endtask

    // Called at a falling edge, returns just after it with the retire outputs settled
    task automatic wait_retire(input qu_pkg::rob_addr_t slot);
        int waited;
        waited = 0;
        #1;
        while (retire_en !== 1'b1)
        begin
            if (waited == RETIRE_LIMIT)
            begin
                fail_run($sformatf("ROB slot %0d did not retire within %0d cycles",
                                   slot, RETIRE_LIMIT));
            end
            next_cycle();
            #1;
            waited++;
        end
        check_rob(retire_rob_addr, slot, "retire_rob_addr");
        check_bit(free_reg_en, 1'b1, "free_reg_en");
    endtask

    task automatic test_reset_state();
        next_cycle();
        #1;
        check_bit(retire_en, 1'b0, "retire_en");
        check_strobe(dmem_wr_en, 4'b0000, "dmem_wr_en");
        check_bit(dmem_rd_en, 1'b0, "dmem_rd_en");
        check_bit(mispredicted_branch, 1'b0, "mispredicted_branch");
        check_bit(rob_full, 1'b0, "rob_full");
        check_rob(rob_tail_ptr, '0, "rob_tail_ptr");
    endtask

    task automatic test_out_of_order_complete();
        qu_pkg::rob_addr_t    slot [3];
        qu_pkg::phy_rf_addr_t dest [3];
        qu_pkg::phy_rf_addr_t old [3];
        qu_pkg::phy_rf_data_t value [3];
        for (int k = 0; k < 3; k++)
        begin
            dest[k] = qu_pkg::phy_rf_addr_t'(5 + k);
            old[k] = qu_pkg::phy_rf_addr_t'(33 + k);
            value[k] = random_bits(32);
            allocate(dest[k], slot[k]);
        end
        for (int k = 0; k < 3; k++)
        begin
            next_cycle();
            busy_rd_addr = dest[k];
            #1;
            check_bit(busy_rd_data, 1'b1, "busy_rd_data");
        end
        // Completion order 2, 0, 1
        complete(qu_pkg::OPTYPE_ALU, qu_pkg::FUNCT3_SW, slot[2], dest[2], old[2], '0, value[2], 1'b0);
        complete(qu_pkg::OPTYPE_ALU, qu_pkg::FUNCT3_SW, slot[0], dest[0], old[0], '0, value[0], 1'b0);
        complete(qu_pkg::OPTYPE_ALU, qu_pkg::FUNCT3_SW, slot[1], dest[1], old[1], '0, value[1], 1'b0);
        for (int k = 0; k < 3; k++)
        begin
            wait_retire(slot[k]);
            check_data(retire_value, value[k], "retire_value");
            check_addr(free_reg_addr, old[k], "free_reg_addr");
            next_cycle();
        end
        for (int k = 0; k < 3; k++)
        begin
            rf_rd_addr = dest[k];
            busy_rd_addr = dest[k];
            #1;
            check_data(rf_rd_data, value[k], "rf_rd_data");
            check_bit(busy_rd_data, 1'b0, "busy_rd_data");
            next_cycle();
        end
    endtask

    task automatic test_store_strobes();
        qu_pkg::funct3_t      widths [3];
        logic [3:0]           strobes [3];
        qu_pkg::phy_rf_data_t addrs [3];
        qu_pkg::phy_rf_data_t datas [3];
        qu_pkg::rob_addr_t    slot;
        store_rec_t           rec;
        widths[0] = qu_pkg::FUNCT3_SB;
        widths[1] = qu_pkg::FUNCT3_SH;
        widths[2] = qu_pkg::FUNCT3_SW;
        strobes[0] = 4'b0001;
        strobes[1] = 4'b0011;
        strobes[2] = 4'b1111;
        store_log.delete();
        for (int k = 0; k < 3; k++)
        begin
            addrs[k] = random_bits(32);
            datas[k] = random_bits(32);
            allocate('0, slot);
            complete(qu_pkg::OPTYPE_STORE, widths[k], slot, '0, qu_pkg::phy_rf_addr_t'(40 + k),
                     datas[k], addrs[k], 1'b0);
            wait_retire(slot);
            check_strobe(dmem_wr_en, strobes[k], "dmem_wr_en");
            check_data(dmem_addr, addrs[k], "dmem_addr");
            check_data(dmem_data, datas[k], "dmem_data");
        end
        if (store_log.size() != 3)
        begin
            fail_run($sformatf("Memory saw %0d stores instead of 3", store_log.size()));
        end
        for (int k = 0; k < 3; k++)
        begin
            rec = store_log.pop_front();
            check_strobe(rec.strb, strobes[k], "logged strobe");
            check_data(rec.addr, addrs[k], "logged address");
            check_data(rec.data, datas[k], "logged data");
        end
    endtask

    task automatic test_load_stalls_head();
        qu_pkg::rob_addr_t    load_slot;
        qu_pkg::rob_addr_t    alu_slot;
        qu_pkg::phy_rf_data_t load_addr;
        qu_pkg::phy_rf_data_t alu_value;
        qu_pkg::phy_rf_data_t load_data;
        load_addr = random_bits(32);
        alu_value = random_bits(32);
        load_data = mem[load_addr[5:2]];
        allocate(6'd12, load_slot);
        allocate(6'd13, alu_slot);
        // The younger ALU op completes first
        complete(qu_pkg::OPTYPE_ALU, qu_pkg::FUNCT3_SW, alu_slot, 6'd13, 6'd43, '0, alu_value, 1'b0);
        complete(qu_pkg::OPTYPE_LOAD, qu_pkg::FUNCT3_SW, load_slot, 6'd12, 6'd42, '0, load_addr,
                 1'b0);
        next_cycle();
        #1;
        check_bit(dmem_rd_en, 1'b1, "dmem_rd_en");
        check_bit(retire_en, 1'b0, "retire_en");
        check_data(dmem_addr, load_addr, "dmem_addr");
        next_cycle();
        wait_retire(load_slot);
        check_data(retire_value, load_data, "retire_value");
        check_addr(free_reg_addr, 6'd42, "free_reg_addr");
        next_cycle();
        wait_retire(alu_slot);
        check_data(retire_value, alu_value, "retire_value");
        next_cycle();
        rf_rd_addr = 6'd12;
        #1;
        check_data(rf_rd_data, load_data, "rf_rd_data");
    endtask

    task automatic test_branch_flags();
        qu_pkg::rob_addr_t slot_taken;
        qu_pkg::rob_addr_t slot_plain;
        qu_pkg::pc_t       target_taken;
        qu_pkg::pc_t       target_plain;
        target_taken = random_bits(32);
        target_plain = random_bits(32);
        allocate('0, slot_taken);
        allocate('0, slot_plain);
        complete(qu_pkg::OPTYPE_BRANCH, qu_pkg::FUNCT3_SW, slot_taken, '0, 6'd44, '0, target_taken,
                 1'b1);
        complete(qu_pkg::OPTYPE_BRANCH, qu_pkg::FUNCT3_SW, slot_plain, '0, 6'd45, '0, target_plain,
                 1'b0);
        wait_retire(slot_taken);
        check_bit(mispredicted_branch, 1'b1, "mispredicted_branch");
        check_data(pc_to_jump, target_taken, "pc_to_jump");
        next_cycle();
        wait_retire(slot_plain);
        check_bit(mispredicted_branch, 1'b0, "mispredicted_branch");
    endtask

    task automatic test_full_flag();
        qu_pkg::rob_addr_t    first_slot;
        qu_pkg::rob_addr_t    slot;
        qu_pkg::phy_rf_data_t value;
        value = random_bits(32);
        allocate('0, first_slot);
        for (int k = 1; k < ROB_DEPTH - 1; k++)
        begin
            allocate('0, slot);
        end
        next_cycle();
        #1;
        check_bit(rob_full, 1'b1, "rob_full");
        complete(qu_pkg::OPTYPE_ALU, qu_pkg::FUNCT3_SW, first_slot, 6'd20, 6'd50, '0, value, 1'b0);
        wait_retire(first_slot);
        next_cycle();
        #1;
        check_bit(rob_full, 1'b0, "rob_full");
    endtask

    // Data memory model, answers loads after 1 to 3 cycles and logs stores
    initial
    begin
        int delay;
        dmem_valid_in = 1'b0;
        dmem_data_in = '0;
        forever
        begin
            @(negedge clk);
            dmem_valid_in = 1'b0;
            if ((|dmem_wr_en) === 1'b1)
            begin
                store_log.push_back({dmem_wr_en, dmem_addr, dmem_data});
            end
            if (dmem_rd_en === 1'b1)
            begin
                delay = 1 + int'(random_bits(2)) % 3;
                repeat (delay) @(negedge clk);
                dmem_valid_in = 1'b1;
                dmem_data_in = mem[dmem_addr[5:2]];
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Watchdog timeout, the tests ran past their cycle budget");
    end

    initial
    begin
        rst = 1'b1;
        value_in = '0;
        comp_result_in = 1'b0;
        op_in = '0;
        rob_incr_tail_ptr = 1'b0;
        busy_set_en = 1'b0;
        busy_set_addr = '0;
        rf_rd_addr = '0;
        busy_rd_addr = '0;
        tail_model = 0;
        for (int i = 0; i < 16; i++)
        begin
            mem[i] = 32'h9e3779b9 * (i + 1);
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        test_reset_state();
        test_out_of_order_complete();
        test_store_strobes();
        test_load_stalls_head();
        test_branch_flags();
        test_full_flag();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- source/retire_top.sv
// Retire back end top level with retire stage, register file and busy table
module retire_top #(
    parameter int ROB_DEPTH = 16,
    parameter int PHY_REGS  = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  qu_pkg::phy_rf_data_t value_in,
    input  logic                 comp_result_in,
    input  qu_pkg::res_st_cell_t op_in,
    input  logic                 rob_incr_tail_ptr,
    output qu_pkg::rob_addr_t    rob_tail_ptr,
    output logic                 rob_full,
    output logic                 free_reg_en,
    output qu_pkg::phy_rf_addr_t free_reg_addr,
    output logic                 retire_en,
    output qu_pkg::rob_addr_t    retire_rob_addr,
    output qu_pkg::phy_rf_data_t retire_value,
    output logic                 mispredicted_branch,
    output qu_pkg::pc_t          pc_to_jump,
    output logic [3:0]           dmem_wr_en,
    output logic                 dmem_rd_en,
    output logic [31:0]          dmem_addr,
    output logic [31:0]          dmem_data,
    input  logic                 dmem_valid_in,
    input  logic [31:0]          dmem_data_in,
    input  logic                 busy_set_en,
    input  qu_pkg::phy_rf_addr_t busy_set_addr,
    input  qu_pkg::phy_rf_addr_t rf_rd_addr,
    output qu_pkg::phy_rf_data_t rf_rd_data,
    input  qu_pkg::phy_rf_addr_t busy_rd_addr,
    output logic                 busy_rd_data
);

    logic                 rf_wr_en;
    qu_pkg::phy_rf_addr_t rf_wr_addr;
    qu_pkg::phy_rf_data_t rf_wr_data;
    logic                 busy_clr_en;
    qu_pkg::phy_rf_addr_t busy_clr_addr;

    retire #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_retire (
        .clk                (clk),
        .rst                (rst),
        .value_in           (value_in),
        .comp_result_in     (comp_result_in),
        .op_in              (op_in),
        .rob_incr_tail_ptr  (rob_incr_tail_ptr),
        .rob_tail_ptr       (rob_tail_ptr),
        .rob_full           (rob_full),
        .phy_rf_wr_en       (rf_wr_en),
        .phy_rf_wr_addr     (rf_wr_addr),
        .phy_rf_wr_data     (rf_wr_data),
        .busy_table_wr_en   (busy_clr_en),
        .busy_table_wr_addr (busy_clr_addr),
        .free_reg_en        (free_reg_en),
        .free_reg_addr      (free_reg_addr),
        .retire_en          (retire_en),
        .retire_rob_addr    (retire_rob_addr),
        .retire_value       (retire_value),
        .mispredicted_branch(mispredicted_branch),
        .pc_to_jump         (pc_to_jump),
        .dmem_wr_en         (dmem_wr_en),
        .dmem_rd_en         (dmem_rd_en),
        .dmem_addr          (dmem_addr),
        .dmem_data          (dmem_data),
        .dmem_valid_in      (dmem_valid_in),
        .dmem_data_in       (dmem_data_in)
    );

    phy_rf #(
        .PHY_REGS(PHY_REGS)
    ) u_phy_rf (
        .clk    (clk),
        .rst    (rst),
        .wr_en  (rf_wr_en),
        .wr_addr(rf_wr_addr),
        .wr_data(rf_wr_data),
        .rd_addr(rf_rd_addr),
        .rd_data(rf_rd_data)
    );

    busy_table #(
        .PHY_REGS(PHY_REGS)
    ) u_busy_table (
        .clk     (clk),
        .rst     (rst),
        .set_en  (busy_set_en),
        .set_addr(busy_set_addr),
        .clr_en  (busy_clr_en),
        .clr_addr(busy_clr_addr),
        .rd_addr (busy_rd_addr),
        .rd_busy (busy_rd_data)
    );

endmodule

//--- source/busy_table.sv
// Busy bit per physical register with set, clear and one read port
module busy_table #(
    parameter int PHY_REGS = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 set_en,
    input  qu_pkg::phy_rf_addr_t set_addr,
    input  logic                 clr_en,
    input  qu_pkg::phy_rf_addr_t clr_addr,
    input  qu_pkg::phy_rf_addr_t rd_addr,
    output logic                 rd_busy
);

    logic [PHY_REGS-1:0] busy;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= '0;
        end
        else
        begin
            if (clr_en)
            begin
                busy[clr_addr] <= 1'b0;
            end
            // Set comes last so it wins on the same register
            if (set_en)
            begin
                busy[set_addr] <= 1'b1;
            end
        end
    end

    assign rd_busy = busy[rd_addr];

endmodule

//--- source/phy_rf.sv
// Physical register file, one write port and one asynchronous read port
module phy_rf #(
    parameter int PHY_REGS = 64
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_en,
    input  qu_pkg::phy_rf_addr_t wr_addr,
    input  qu_pkg::phy_rf_data_t wr_data,
    input  qu_pkg::phy_rf_addr_t rd_addr,
    output qu_pkg::phy_rf_data_t rd_data
);

    qu_pkg::phy_rf_data_t regs [PHY_REGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < PHY_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        // Register 0 stays zero
        else if (wr_en && wr_addr != '0)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

//--- source/retire.sv
// Retire stage with ROB pointers, completion write, full flag and in-order retire decision
module retire #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  qu_pkg::phy_rf_data_t value_in,
    input  logic                 comp_result_in,
    input  qu_pkg::res_st_cell_t op_in,
    input  logic                 rob_incr_tail_ptr,
    output qu_pkg::rob_addr_t    rob_tail_ptr,
    output logic                 rob_full,
    output logic                 phy_rf_wr_en,
    output qu_pkg::phy_rf_addr_t phy_rf_wr_addr,
    output qu_pkg::phy_rf_data_t phy_rf_wr_data,
    output logic                 busy_table_wr_en,
    output qu_pkg::phy_rf_addr_t busy_table_wr_addr,
    output logic                 free_reg_en,
    output qu_pkg::phy_rf_addr_t free_reg_addr,
    output logic                 retire_en,
    output qu_pkg::rob_addr_t    retire_rob_addr,
    output qu_pkg::phy_rf_data_t retire_value,
    output logic                 mispredicted_branch,
    output qu_pkg::pc_t          pc_to_jump,
    output logic [3:0]           dmem_wr_en,
    output logic                 dmem_rd_en,
    output logic [31:0]          dmem_addr,
    output logic [31:0]          dmem_data,
    input  logic                 dmem_valid_in,
    input  logic [31:0]          dmem_data_in
);

    localparam int PTR_W = qu_pkg::ROB_ADDR_WIDTH + 1;
    localparam int DEST_PAD_W = 32 - qu_pkg::PHY_RF_ADDR_WIDTH;
    localparam logic [PTR_W-1:0] DEPTH_PAD = PTR_W'(ROB_DEPTH);
    localparam qu_pkg::rob_addr_t LAST_SLOT = qu_pkg::rob_addr_t'(ROB_DEPTH - 1);

    qu_pkg::rob_addr_t head_ptr;
    qu_pkg::rob_addr_t tail_ptr;
    logic [PTR_W-1:0]  head_pad;
    logic [PTR_W-1:0]  tail_pad;
    logic [PTR_W-1:0]  used;

    qu_pkg::optype_t   op_type;
    logic              op_valid;
    logic              wr1_en;
    qu_pkg::rob_cell_t wr1_in;
    qu_pkg::rob_cell_t wr2_in;
    qu_pkg::rob_cell_t head_cell;
    qu_pkg::rob_cell_t slot_cell;

    logic              head_valid;
    logic              has_dest;

    // Completion into the slot named by the micro-op
    assign op_type = op_in.op.optype;
    assign op_valid = op_type[0];
    // Drop a repeated completion of a slot still waiting to retire
    assign wr1_en = op_valid && (slot_cell.state != qu_pkg::ROB_STATE_DONE);

    always_comb
    begin
        wr1_in.value = (op_type == qu_pkg::OPTYPE_STORE) ? op_in.vk : value_in;
        wr1_in.dest = (op_type == qu_pkg::OPTYPE_STORE) ? value_in
                                                         : {{DEST_PAD_W{1'b0}}, op_in.dest};
        wr1_in.phyreg_old = op_in.phyreg_old;
        wr1_in.store = (op_type == qu_pkg::OPTYPE_STORE);
        wr1_in.load = (op_type == qu_pkg::OPTYPE_LOAD);
        wr1_in.mispredicted_branch = (op_type == qu_pkg::OPTYPE_BRANCH) && comp_result_in;
        wr1_in.ldst_funct3 = op_in.op.funct3;
        wr1_in.state = qu_pkg::ROB_STATE_DONE;
    end

    rob #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_rob (
        .clk     (clk),
        .rst     (rst),
        .wr1_en  (wr1_en),
        .wr1_addr(op_in.rob_addr),
        .wr1_in  (wr1_in),
        .wr2_en  (retire_en),
        .wr2_addr(head_ptr),
        .wr2_in  (wr2_in),
        .rd1_addr(head_ptr),
        .rd1_out (head_cell),
        .rd2_addr(op_in.rob_addr),
        .rd2_out (slot_cell)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end
        else
        begin
            if (rob_incr_tail_ptr)
            begin
                tail_ptr <= (tail_ptr == LAST_SLOT) ? '0 : tail_ptr + 1'b1;
            end
            if (retire_en)
            begin
                head_ptr <= (head_ptr == LAST_SLOT) ? '0 : head_ptr + 1'b1;
            end
        end
    end

    // Occupancy from the padded pointers
    assign head_pad = {1'b0, head_ptr};
    assign tail_pad = {1'b0, tail_ptr};
    assign used = (tail_pad >= head_pad) ? tail_pad - head_pad
                                         : tail_pad + DEPTH_PAD - head_pad;
    assign rob_full = (used == DEPTH_PAD - 1'b1);
    assign rob_tail_ptr = tail_ptr;

    assign head_valid = (head_cell.state == qu_pkg::ROB_STATE_DONE) && (head_ptr != tail_ptr);
    assign has_dest = (head_cell.dest[qu_pkg::PHY_RF_ADDR_WIDTH-1:0] != '0);

    always_comb
    begin
        retire_en = 1'b0;
        phy_rf_wr_en = 1'b0;
        mispredicted_branch = 1'b0;
        dmem_wr_en = 4'b0000;
        dmem_rd_en = 1'b0;
        phy_rf_wr_data = head_cell.load ? dmem_data_in : head_cell.value;

        if (head_valid)
        begin
            if (head_cell.store)
            begin
                case (head_cell.ldst_funct3)
                    qu_pkg::FUNCT3_SB: dmem_wr_en = 4'b0001;
                    qu_pkg::FUNCT3_SH: dmem_wr_en = 4'b0011;
                    qu_pkg::FUNCT3_SW: dmem_wr_en = 4'b1111;
                    default:           dmem_wr_en = 4'b0000;
                endcase
                retire_en = 1'b1;
            end
            else if (head_cell.load)
            begin
                // Wait at the head for the memory answer
                dmem_rd_en = 1'b1;
                retire_en = dmem_valid_in;
                phy_rf_wr_en = dmem_valid_in && has_dest;
            end
            else
            begin
                retire_en = 1'b1;
                phy_rf_wr_en = has_dest;
                mispredicted_branch = head_cell.mispredicted_branch;
            end
        end
    end

    assign phy_rf_wr_addr = head_cell.dest[qu_pkg::PHY_RF_ADDR_WIDTH-1:0];
    assign busy_table_wr_en = phy_rf_wr_en;
    assign busy_table_wr_addr = head_cell.dest[qu_pkg::PHY_RF_ADDR_WIDTH-1:0];

    assign free_reg_en = retire_en;
    assign free_reg_addr = head_cell.phyreg_old;
    assign retire_rob_addr = head_ptr;
    assign retire_value = phy_rf_wr_data;
    assign pc_to_jump = head_cell.value;

    assign dmem_addr = head_cell.store ? head_cell.dest : head_cell.value;
    assign dmem_data = head_cell.value;

    // Retired slots cannot retire again on a later lap
    always_comb
    begin
        wr2_in = head_cell;
        wr2_in.state = qu_pkg::ROB_STATE_RETIRED;
    end

endmodule

//--- source/rob.sv
// Reorder buffer storage with two write ports and two asynchronous read ports
module rob #(
    parameter int ROB_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr1_en,
    input  qu_pkg::rob_addr_t wr1_addr,
    input  qu_pkg::rob_cell_t wr1_in,
    input  logic              wr2_en,
    input  qu_pkg::rob_addr_t wr2_addr,
    input  qu_pkg::rob_cell_t wr2_in,
    input  qu_pkg::rob_addr_t rd1_addr,
    output qu_pkg::rob_cell_t rd1_out,
    input  qu_pkg::rob_addr_t rd2_addr,
    output qu_pkg::rob_cell_t rd2_out
);

    qu_pkg::rob_cell_t cells [ROB_DEPTH];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < ROB_DEPTH; i++)
            begin
                cells[i].state <= qu_pkg::ROB_STATE_EMPTY;
            end
        end
        else
        begin
            if (wr1_en)
            begin
                cells[wr1_addr] <= wr1_in;
            end
            // Port 2 wins on the same slot
            if (wr2_en)
            begin
                cells[wr2_addr] <= wr2_in;
            end
        end
    end

    assign rd1_out = cells[rd1_addr];
    assign rd2_out = cells[rd2_addr];

endmodule

//--- source/qu_pkg.sv
// Shared widths, micro-op and ROB entry structs, ROB states and funct3 codes
package qu_pkg;

    // Physical register file
    localparam int PHY_RF_ADDR_WIDTH = 6;

    typedef logic [PHY_RF_ADDR_WIDTH-1:0] phy_rf_addr_t;
    typedef logic [31:0] phy_rf_data_t;
    typedef logic [31:0] pc_t;

    // Reorder buffer pointers
    localparam int ROB_ADDR_WIDTH = 4;

    typedef logic [ROB_ADDR_WIDTH-1:0] rob_addr_t;

    // Bit 0 marks a valid micro-op
    typedef enum logic [2:0] {
        OPTYPE_NONE   = 3'b000,
        OPTYPE_ALU    = 3'b001,
        OPTYPE_LOAD   = 3'b011,
        OPTYPE_STORE  = 3'b101,
        OPTYPE_BRANCH = 3'b111
    } optype_t;

    // Access width, same encoding for loads and stores
    typedef enum logic [2:0] {
        FUNCT3_SB = 3'b000,
        FUNCT3_SH = 3'b001,
        FUNCT3_SW = 3'b010
    } funct3_t;

    typedef enum logic [1:0] {
        ROB_STATE_EMPTY   = 2'd0,
        ROB_STATE_DONE    = 2'd1,
        ROB_STATE_RETIRED = 2'd2
    } rob_state_t;

    typedef struct packed {
        optype_t optype;
        funct3_t funct3;
    } uop_t;

    // Executed micro-op as it leaves the completion FIFO
    typedef struct packed {
        uop_t         op;
        rob_addr_t    rob_addr;
        phy_rf_addr_t dest;
        phy_rf_addr_t phyreg_old;
        // Store data
        phy_rf_data_t vk;
    } res_st_cell_t;

    // One ROB slot
    typedef struct packed {
        // Result, store data or branch target
        phy_rf_data_t value;
        // Store address, or the zero-padded destination register
        logic [31:0]  dest;
        phy_rf_addr_t phyreg_old;
        logic         store;
        logic         load;
        logic         mispredicted_branch;
        funct3_t      ldst_funct3;
        rob_state_t   state;
    } rob_cell_t;

endpackage
